//--- tb.f
+incdir+.
qpu_pkg.sv
qpu_decoder.sv
qpu_alu.sv
qpu_meas_tracker.sv
qpu_wbck_arbiter.sv
qpu_classical_regfile.sv
qpu_quantum_issue.sv
qpu_event_queue.sv
qpu_exu_top.sv
tb_qpu_exu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execution unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_qpu_exu -Mdir obj_dir -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1

//--- tb_qpu_exu.sv
`timescale 1ns/1ps
`include "qpu_macros.svh"

module tb_qpu_exu import qpu_pkg::*;
();

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 16;
  localparam int CYCLES_PER_ROW  = 8;
  localparam int WATCHDOG_MARGIN = 64;

  typedef enum logic [1:0] {CHK_NONE, CHK_TABLE, CHK_MODEL} chk_e;

  // One stimulus row, one clock cycle
  typedef struct packed {
    logic       ivalid;
    qpu_word_t  instr;
    logic       mvalid;
    qpu_qmask_t mqubits;
    logic       trig;
    qpu_time_t  timer;
    qpu_ridx_t  ridx;
    chk_e       chk;
    qpu_word_t  exp;
  } row_t;

  logic       clk;
  logic       i_reset;
  logic       i_instr_valid;
  qpu_word_t  i_instr;
  logic       i_meas_valid;
  qpu_qmask_t i_meas_qubits;
  qpu_qmask_t i_meas_results;
  logic       i_trigger;
  qpu_time_t  i_timer;
  qpu_ridx_t  i_host_ridx;
  qpu_word_t  o_host_rdata;
  logic       o_event_valid;
  qpu_event_t o_event;

  // Table, plus side inputs held for the next row
  row_t        rows [$];
  string       names [$];
  logic        next_mvalid;
  qpu_qmask_t  next_mq;
  logic        next_trig;
  qpu_time_t   next_timer;
  logic        table_ready;
  int          n_errors;
  logic [31:0] lfsr;

  // Reference model state
  qpu_word_t      m_regs [`QPU_RF_NUM];
  qpu_qmask_t     m_masks [`QPU_SR_NUM];
  qpu_time_t      m_tp;
  qpu_event_t     m_evq [$];
  qpu_qmask_t     m_pend;
  qpu_qmask_t     m_res;
  qpu_fmr_state_e m_fst;
  qpu_ridx_t      m_frd;
  logic [2:0]     m_fq;
  logic           m_rel;
  qpu_event_t     m_rel_ev;

  qpu_exu_top dut0 (
    .clk(clk), .i_reset(i_reset), .i_instr_valid(i_instr_valid), .i_instr(i_instr),
    .i_meas_valid(i_meas_valid), .i_meas_qubits(i_meas_qubits),
    .i_meas_results(i_meas_results), .i_trigger(i_trigger), .i_timer(i_timer),
    .i_host_ridx(i_host_ridx), .o_host_rdata(o_host_rdata),
    .o_event_valid(o_event_valid), .o_event(o_event)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Instruction words and random bits

  function automatic qpu_word_t alu_instr(input logic [3:0] op, input qpu_ridx_t rd,
                                          input qpu_ridx_t rs1, input qpu_ridx_t rs2);
    return {op, rd, rs1, rs2, 16'h0000};
  endfunction

  function automatic qpu_word_t addi_instr(input qpu_ridx_t rd, input qpu_ridx_t rs1,
                                           input logic [15:0] imm);
    return {4'd6, rd, rs1, 4'h0, imm};
  endfunction

  function automatic qpu_word_t smis_instr(input qpu_ridx_t sreg, input qpu_qmask_t mask);
    return {4'd1, sreg, 16'h0000, mask};
  endfunction

  function automatic qpu_word_t qwait_instr(input logic [19:0] amt);
    return {4'd2, 8'h00, amt};
  endfunction

  // QOP or MEASURE on a mask register
  function automatic qpu_word_t quantum_instr(input logic [3:0] op, input qpu_ridx_t sreg,
                                              input qpu_gate_t gate);
    return {op, sreg, gate, 16'h0000};
  endfunction

  function automatic qpu_word_t fmr_instr(input qpu_ridx_t rd, input logic [2:0] qubit);
    return {4'd5, rd, 21'h0, qubit};
  endfunction

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks

  task automatic abort_run();
    n_errors++;
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input qpu_word_t exp, input qpu_word_t act);
    if (act !== exp)
    begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_event(input string name, input qpu_event_t exp, input qpu_event_t act);
    if (act !== exp)
    begin
      $display("[ERROR] %s: expected tp=%h gate=%h mask=%h, actual tp=%h gate=%h mask=%h",
               name, exp.tp, exp.gate, exp.mask, act.tp, act.gate, act.mask);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("[ERROR] %s: expected event_valid %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model, one call per clock

  task automatic model_step(input row_t r, input qpu_qmask_t mres);
    logic [3:0] op;
    qpu_ridx_t  rd;
    qpu_ridx_t  rs1;
    qpu_ridx_t  rs2;
    logic [2:0] q;
    qpu_qmask_t cov;
    logic       alu_wr;
    qpu_word_t  alu_val;
    logic       fmr_wr;
    qpu_event_t ev;
    op  = r.ivalid ? r.instr[31:28] : 4'd0;
    rd  = r.instr[27:24];
    rs1 = r.instr[23:20];
    rs2 = r.instr[19:16];
    q   = r.instr[2:0];
    cov = r.mvalid ? r.mqubits : '0;
    // Release sees the queue as it was before this cycle's push
    m_rel = 1'b0;
    if ((m_evq.size() != 0) && r.trig && (r.timer >= m_evq[0].tp))
    begin
      m_rel    = 1'b1;
      m_rel_ev = m_evq.pop_front();
    end
    alu_wr = 1'b1;
    case (op)
      OP_ADD:  alu_val = m_regs[rs1] + m_regs[rs2];
      OP_SUB:  alu_val = m_regs[rs1] - m_regs[rs2];
      OP_ADDI: alu_val = m_regs[rs1] + {{16{r.instr[15]}}, r.instr[15:0]};
      default: alu_wr = 1'b0;
    endcase
    // FMR, the ALU takes the port first
    fmr_wr = 1'b0;
    if ((m_fst == FMR_IDLE) && (op == OP_FMR))
    begin
      m_frd = rd;
      m_fq  = q;
      if (m_pend[q] && !cov[q])
        m_fst = FMR_WAIT;
      else if (alu_wr)
        m_fst = FMR_WRITE;
      else
        fmr_wr = 1'b1;
    end
    else if ((m_fst == FMR_WAIT) && cov[m_fq])
      m_fst = FMR_WRITE;
    else if ((m_fst == FMR_WRITE) && !alu_wr)
    begin
      fmr_wr = 1'b1;
      m_fst  = FMR_IDLE;
    end
    if (alu_wr && (rd != '0))
      m_regs[rd] = alu_val;
    // A result returning this cycle is used directly
    if (fmr_wr && (m_frd != '0))
      m_regs[m_frd] = {31'h0, cov[m_fq] ? mres[m_fq] : m_res[m_fq]};
    // Events carry the time point and mask from before this cycle
    if ((op == OP_QOP) || (op == OP_MEASURE))
    begin
      ev.tp   = m_tp;
      ev.gate = (op == OP_MEASURE) ? 8'hff : r.instr[23:16];
      ev.mask = m_masks[rd];
      m_evq.push_back(ev);
    end
    m_pend = (m_pend & ~cov) | ((op == OP_MEASURE) ? m_masks[rd] : '0);
    m_res  = (m_res & ~cov) | (mres & cov);
    if (op == OP_SMIS)
      m_masks[rd] = r.instr[7:0];
    if (op == OP_QWAIT)
      m_tp = m_tp + {12'h0, r.instr[19:0]};
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table

  // Side inputs for the next row only
  task automatic set_meas(input qpu_qmask_t mq);
    next_mvalid = 1'b1;
    next_mq     = mq;
  endtask

  task automatic set_timer(input logic trig, input qpu_time_t timer);
    next_trig  = trig;
    next_timer = timer;
  endtask

  task automatic add_row(input string name, input qpu_word_t instr, input qpu_ridx_t ridx,
                         input chk_e chk, input qpu_word_t exp);
    row_t r;
    r = '{ivalid: 1'b1, instr: instr, mvalid: next_mvalid, mqubits: next_mq,
          trig: next_trig, timer: next_timer, ridx: ridx, chk: chk, exp: exp};
    rows.push_back(r);
    names.push_back(name);
    next_mvalid = 1'b0;
    next_mq     = '0;
    next_trig   = 1'b0;
    next_timer  = '0;
  endtask

  task automatic build_table();
    // Arithmetic, r0 stays zero
    add_row("addi_pos", addi_instr(1, 0, 16'h1234), 1, CHK_TABLE, 32'h0000_1234);
    add_row("addi_neg", addi_instr(2, 0, 16'hfffb), 2, CHK_TABLE, 32'hffff_fffb);
    add_row("add", alu_instr(OP_ADD, 3, 1, 2), 3, CHK_TABLE, 32'h0000_122f);
    add_row("sub", alu_instr(OP_SUB, 4, 2, 1), 4, CHK_TABLE, 32'hffff_edc7);
    add_row("write_r0", addi_instr(0, 0, 16'h0009), 0, CHK_TABLE, 32'h0);
    add_row("addi_chain", addi_instr(5, 3, 16'h0001), 5, CHK_TABLE, 32'h0000_1230);
    // Masks, time point and three events
    add_row("smis_s1", smis_instr(1, 8'h05), 0, CHK_NONE, 32'h0);
    add_row("smis_s2", smis_instr(2, 8'h30), 0, CHK_NONE, 32'h0);
    add_row("qop_s1", quantum_instr(OP_QOP, 1, 8'h11), 0, CHK_NONE, 32'h0);
    add_row("qwait_100", qwait_instr(20'd100), 0, CHK_NONE, 32'h0);
    add_row("qop_s2", quantum_instr(OP_QOP, 2, 8'h22), 0, CHK_NONE, 32'h0);
    add_row("qwait_50", qwait_instr(20'd50), 0, CHK_NONE, 32'h0);
    add_row("measure_s1", quantum_instr(OP_MEASURE, 1, 8'h00), 0, CHK_NONE, 32'h0);
    set_timer(1'b0, 32'd1000);
    add_row("trig_low", 32'h0, 0, CHK_NONE, 32'h0);
    set_timer(1'b1, 32'd0);
    add_row("release_1", 32'h0, 0, CHK_NONE, 32'h0);
    set_timer(1'b1, 32'd99);
    add_row("timer_below", 32'h0, 0, CHK_NONE, 32'h0);
    set_timer(1'b1, 32'd100);
    add_row("release_2", 32'h0, 0, CHK_NONE, 32'h0);
    // FMR waits for the strobe
    add_row("fmr_pending", fmr_instr(4, 0), 4, CHK_MODEL, 32'h0);
    add_row("fmr_hold", 32'h0, 4, CHK_MODEL, 32'h0);
    // Strobe also returns q1 and q3, which are not pending
    set_meas(8'h0f);
    add_row("meas_return", 32'h0, 4, CHK_MODEL, 32'h0);
    add_row("fmr_done", 32'h0, 4, CHK_MODEL, 32'h0);
    add_row("fmr_stored", fmr_instr(5, 3), 5, CHK_MODEL, 32'h0);
    add_row("fmr_never", fmr_instr(3, 7), 3, CHK_MODEL, 32'h0);
    // FMR write collides with an ALU write
    add_row("smis_s3", smis_instr(3, 8'h02), 0, CHK_NONE, 32'h0);
    add_row("measure_s3", quantum_instr(OP_MEASURE, 3, 8'h00), 0, CHK_NONE, 32'h0);
    add_row("fmr_q1", fmr_instr(2, 1), 2, CHK_MODEL, 32'h0);
    set_meas(8'h02);
    add_row("meas_q1", 32'h0, 2, CHK_MODEL, 32'h0);
    add_row("alu_vs_fmr", addi_instr(9, 0, 16'h0055), 9, CHK_TABLE, 32'h0000_0055);
    add_row("fmr_after_alu", 32'h0, 2, CHK_MODEL, 32'h0);
    add_row("alu_kept", 32'h0, 9, CHK_TABLE, 32'h0000_0055);
    // Result arriving in the FMR cycle
    add_row("measure_again", quantum_instr(OP_MEASURE, 1, 8'h00), 0, CHK_NONE, 32'h0);
    set_meas(8'h04);
    add_row("fmr_bypass", fmr_instr(9, 2), 9, CHK_MODEL, 32'h0);
    add_row("fmr_q0_wait", fmr_instr(1, 0), 1, CHK_MODEL, 32'h0);
    set_meas(8'h01);
    add_row("meas_q0_alu", addi_instr(12, 1, 16'hffff), 12, CHK_TABLE, 32'h0000_1233);
    add_row("fmr_q0_done", 32'h0, 1, CHK_MODEL, 32'h0);
    // Drain the queue in issue order
    set_timer(1'b1, 32'd149);
    add_row("timer_149", 32'h0, 0, CHK_NONE, 32'h0);
    set_timer(1'b1, 32'd150);
    add_row("release_3", 32'h0, 0, CHK_NONE, 32'h0);
    set_timer(1'b1, 32'd200);
    add_row("release_4", 32'h0, 0, CHK_NONE, 32'h0);
    set_timer(1'b1, 32'd200);
    add_row("release_5", 32'h0, 0, CHK_NONE, 32'h0);
    set_timer(1'b1, 32'd1000);
    add_row("queue_empty", 32'h0, 12, CHK_TABLE, 32'h0000_1233);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial
  begin
    row_t       r;
    qpu_qmask_t mres;
    i_reset        = 1'b1;
    i_instr_valid  = 1'b0;
    i_instr        = '0;
    i_meas_valid   = 1'b0;
    i_meas_qubits  = '0;
    i_meas_results = '0;
    i_trigger      = 1'b0;
    i_timer        = '0;
    i_host_ridx    = '0;
    next_mvalid    = 1'b0;
    next_mq        = '0;
    next_trig      = 1'b0;
    next_timer     = '0;
    n_errors       = 0;
    lfsr           = 32'h9795_02cb;
    table_ready    = 1'b0;
    for (int i = 0; i < `QPU_RF_NUM; i++)
      m_regs[i] = '0;
    for (int i = 0; i < `QPU_SR_NUM; i++)
      m_masks[i] = '0;
    m_tp   = '0;
    m_pend = '0;
    m_res  = '0;
    m_fst  = FMR_IDLE;
    m_frd  = '0;
    m_fq   = '0;
    build_table();
    table_ready = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;

    // Clean state after reset
    for (int i = 0; i < `QPU_RF_NUM; i++)
    begin
      i_host_ridx = qpu_ridx_t'(i);
      @(posedge clk);
      @(negedge clk);
      check_word($sformatf("reset_r%0d", i), 32'h0, o_host_rdata);
      check_flag("reset_no_event", 1'b0, o_event_valid);
    end

    for (int i = 0; i < rows.size(); i++)
    begin
      r    = rows[i];
      mres = '0;
      // One LFSR step per result bit
      if (r.mvalid)
      begin
        for (int b = 0; b < `QPU_QUBIT_NUM; b++)
        begin
          lfsr    = lfsr_next(lfsr);
          mres[b] = lfsr[0];
        end
      end
      i_instr_valid  = r.ivalid;
      i_instr        = r.instr;
      i_meas_valid   = r.mvalid;
      i_meas_qubits  = r.mqubits;
      i_meas_results = mres;
      i_trigger      = r.trig;
      i_timer        = r.timer;
      i_host_ridx    = r.ridx;
      @(posedge clk);
      @(negedge clk);
      model_step(r, mres);
      check_flag(names[i], m_rel, o_event_valid);
      if (m_rel)
        check_event(names[i], m_rel_ev, o_event);
      if (r.chk == CHK_TABLE)
        check_word(names[i], r.exp, o_host_rdata);
      else if (r.chk == CHK_MODEL)
        check_word(names[i], m_regs[r.ridx], o_host_rdata);
    end

    if (n_errors == 0)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
    begin
      abort_run();
    end
  end

  // Bounded by the table length
  initial
  begin
    int unsigned wd_ns;
    wait (table_ready);
    wd_ns = (rows.size() * CYCLES_PER_ROW + WATCHDOG_MARGIN) * CLK_PERIOD;
    #(wd_ns);
    $display("Watchdog expired before the test sequence finished");
    abort_run();
  end

endmodule

//--- qpu_exu_top.sv
`timescale 1ns/1ps

module qpu_exu_top import qpu_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_instr_valid,
  input  qpu_word_t  i_instr,
  input  logic       i_meas_valid,
  input  qpu_qmask_t i_meas_qubits,
  input  qpu_qmask_t i_meas_results,
  input  logic       i_trigger,
  input  qpu_time_t  i_timer,
  input  qpu_ridx_t  i_host_ridx,
  output qpu_word_t  o_host_rdata,
  output logic       o_event_valid,
  output qpu_event_t o_event
);

  // Decode
  qpu_dec_t    dec;
  // Classical datapath
  qpu_ridx_t   rs1_idx;
  qpu_ridx_t   rs2_idx;
  qpu_word_t   rs1_data;
  qpu_word_t   rs2_data;
  // Shared write port
  qpu_wb_req_t alu_wb;
  qpu_wb_req_t fmr_wb;
  logic        fmr_grant;
  qpu_wb_req_t rf_wr;
  // Quantum side
  qpu_qmask_t  issue_mask;
  logic        evq_push;
  qpu_event_t  evq_event;

  qpu_decoder dec0 (.i_instr_valid(i_instr_valid), .i_instr(i_instr), .o_dec(dec));

  qpu_alu alu0 (
    .i_dec(dec), .o_rs1_idx(rs1_idx), .o_rs2_idx(rs2_idx),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .o_wb(alu_wb)
  );

  qpu_meas_tracker trk0 (
    .clk(clk), .i_reset(i_reset), .i_dec(dec),
    .i_meas_valid(i_meas_valid), .i_meas_qubits(i_meas_qubits),
    .i_meas_results(i_meas_results), .i_issue_mask(issue_mask),
    .o_wb(fmr_wb), .i_grant(fmr_grant)
  );

  qpu_wbck_arbiter arb0 (
    .clk(clk), .i_reset(i_reset), .i_alu_wb(alu_wb), .i_fmr_wb(fmr_wb),
    .o_fmr_grant(fmr_grant), .o_rf_wr(rf_wr)
  );

  qpu_classical_regfile rf0 (
    .clk(clk), .i_reset(i_reset), .i_wr(rf_wr),
    .i_rs1_idx(rs1_idx), .i_rs2_idx(rs2_idx), .i_host_ridx(i_host_ridx),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .o_host_rdata(o_host_rdata)
  );

  qpu_quantum_issue qis0 (
    .clk(clk), .i_reset(i_reset), .i_dec(dec),
    .o_issue_mask(issue_mask), .o_push(evq_push), .o_event(evq_event)
  );

  qpu_event_queue evq0 (
    .clk(clk), .i_reset(i_reset), .i_push(evq_push), .i_event(evq_event),
    .i_trigger(i_trigger), .i_timer(i_timer),
    .o_event_valid(o_event_valid), .o_event(o_event)
  );

endmodule

//--- qpu_event_queue.sv
`timescale 1ns/1ps
`include "qpu_macros.svh"

module qpu_event_queue import qpu_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_push,
  input  qpu_event_t i_event,
  input  logic       i_trigger,
  input  qpu_time_t  i_timer,
  output logic       o_event_valid,
  output qpu_event_t o_event
);

  localparam int PTR_W = $clog2(`QPU_EVQ_DEPTH);

  qpu_event_t       mem [`QPU_EVQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             pop;

  assign full = (count == (PTR_W+1)'(`QPU_EVQ_DEPTH));

  // Head leaves once the timer reaches its time point
  assign pop = (count != '0) && i_trigger && (i_timer >= mem[rd_ptr].tp);

  ////////////////////////////////////////////////////////////////////
  // Storage and output stage

  always_ff @(posedge clk)
  begin
    if (i_push)
      mem[wr_ptr] <= i_event;
    if (pop)
      o_event <= mem[rd_ptr];
  end

  ////////////////////////////////////////////////////////////////////
  // Pointers and occupancy

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      o_event_valid <= 1'b0;
    end
    else
    begin
      // One-cycle release pulse
      o_event_valid <= pop;
      if (i_push)
        wr_ptr <= (wr_ptr == PTR_W'(`QPU_EVQ_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(`QPU_EVQ_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      // Push and pop together leave the count alone
      case ({i_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Issue block has no stall path
  a_no_overflow: assert property (@(posedge clk) disable iff (i_reset)
    i_push |-> !full)
    else $error("event pushed into full queue");

endmodule

//--- qpu_quantum_issue.sv
`timescale 1ns/1ps
`include "qpu_macros.svh"

module qpu_quantum_issue import qpu_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  qpu_dec_t   i_dec,
  output qpu_qmask_t o_issue_mask,
  output logic       o_push,
  output qpu_event_t o_event
);

  qpu_qmask_t masks [`QPU_SR_NUM];
  qpu_time_t  time_point;

  ////////////////////////////////////////////////////////////////////
  // Mask registers and time point

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      time_point <= '0;
      for (int i = 0; i < `QPU_SR_NUM; i++)
        masks[i] <= '0;
    end
    else
    begin
      // SMIS loads a mask register
      if (i_dec.opcode == OP_SMIS)
        masks[i_dec.rd] <= i_dec.mask;
      // QWAIT moves the time point forward
      if (i_dec.opcode == OP_QWAIT)
        time_point <= time_point + qpu_time_t'(i_dec.wait_amt);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Event building

  // Selected mask also goes to the measurement tracker
  assign o_issue_mask = masks[i_dec.rd];

  assign o_push = (i_dec.opcode == OP_QOP) || (i_dec.opcode == OP_MEASURE);

  always_comb
  begin
    o_event.tp   = time_point;
    o_event.mask = o_issue_mask;
    // Measurement uses the reserved all-ones gate code
    if (i_dec.opcode == OP_MEASURE)
      o_event.gate = '1;
    else
      o_event.gate = i_dec.gate;
  end

endmodule

//--- qpu_classical_regfile.sv
`timescale 1ns/1ps
`include "qpu_macros.svh"

module qpu_classical_regfile import qpu_pkg::*;
(
  input  logic        clk,
  input  logic        i_reset,
  input  qpu_wb_req_t i_wr,
  input  qpu_ridx_t   i_rs1_idx,
  input  qpu_ridx_t   i_rs2_idx,
  input  qpu_ridx_t   i_host_ridx,
  output qpu_word_t   o_rs1_data,
  output qpu_word_t   o_rs2_data,
  output qpu_word_t   o_host_rdata
);

  qpu_word_t regs [`QPU_RF_NUM];

  // Single write port, r0 never written
  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      for (int i = 0; i < `QPU_RF_NUM; i++)
        regs[i] <= '0;
    end
    else if (i_wr.valid && (i_wr.idx != '0))
    begin
      regs[i_wr.idx] <= i_wr.data;
    end
  end

  // Asynchronous read ports
  assign o_rs1_data   = regs[i_rs1_idx];
  assign o_rs2_data   = regs[i_rs2_idx];
  assign o_host_rdata = regs[i_host_ridx];

endmodule

//--- qpu_wbck_arbiter.sv
`timescale 1ns/1ps
`include "qpu_macros.svh"

module qpu_wbck_arbiter import qpu_pkg::*;
(
  input  logic        clk,
  input  logic        i_reset,
  input  qpu_wb_req_t i_alu_wb,
  input  qpu_wb_req_t i_fmr_wb,
  output logic        o_fmr_grant,
  output qpu_wb_req_t o_rf_wr
);

  localparam int CNT_W = $clog2(`QPU_RF_NUM) + 2;

  logic [CNT_W-1:0] starve_cnt;

  // Fixed priority with the ALU on top
  assign o_fmr_grant = i_fmr_wb.valid && !i_alu_wb.valid;
  assign o_rf_wr     = i_alu_wb.valid ? i_alu_wb : (o_fmr_grant ? i_fmr_wb : '0);

  // Cycles the tracker has been held off, saturating
  always_ff @(posedge clk)
  begin
    if (i_reset)
      starve_cnt <= '0;
    else if (i_fmr_wb.valid && !o_fmr_grant)
    begin
      if (starve_cnt != '1)
        starve_cnt <= starve_cnt + 1'b1;
    end
    else
      starve_cnt <= '0;
  end

  // Back-to-back ALU writes must not keep the tracker out for long
  a_no_starve: assert property (@(posedge clk) disable iff (i_reset)
    (starve_cnt > CNT_W'(`QPU_RF_NUM)) |-> !(i_alu_wb.valid && $past(i_alu_wb.valid)))
    else $error("FMR writeback starved by ALU");

endmodule

//--- qpu_meas_tracker.sv
`timescale 1ns/1ps

module qpu_meas_tracker import qpu_pkg::*;
(
  input  logic        clk,
  input  logic        i_reset,
  input  qpu_dec_t    i_dec,
  input  logic        i_meas_valid,
  input  qpu_qmask_t  i_meas_qubits,
  input  qpu_qmask_t  i_meas_results,
  input  qpu_qmask_t  i_issue_mask,
  output qpu_wb_req_t o_wb,
  input  logic        i_grant
);

  qpu_fmr_state_e state;
  qpu_qmask_t     pending;
  qpu_qmask_t     results;
  qpu_ridx_t      rd_q;
  logic [2:0]     qubit_q;

  logic [2:0]     sel_qubit;
  logic           sel_covered;
  logic           sel_bit;
  logic           fmr_new;
  logic           fmr_hit;

  ////////////////////////////////////////////////////////////////////
  // Result selection

  // Idle looks at the new FMR, otherwise at the captured one
  assign sel_qubit   = (state == FMR_IDLE) ? i_dec.qubit : qubit_q;
  assign sel_covered = i_meas_valid && i_meas_qubits[sel_qubit];
  // Bypass a result that returns this cycle
  assign sel_bit     = sel_covered ? i_meas_results[sel_qubit] : results[sel_qubit];

  assign fmr_new = (state == FMR_IDLE) && (i_dec.opcode == OP_FMR);
  // Result already known, or arriving now
  assign fmr_hit = !pending[i_dec.qubit] || sel_covered;

  always_comb
  begin
    o_wb      = '0;
    o_wb.data = qpu_word_t'(sel_bit);
    if (fmr_new && fmr_hit)
    begin
      o_wb.valid = 1'b1;
      o_wb.idx   = i_dec.rd;
    end
    else if (state == FMR_WRITE)
    begin
      o_wb.valid = 1'b1;
      o_wb.idx   = rd_q;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Pending mask, results and FSM

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      state   <= FMR_IDLE;
      pending <= '0;
      results <= '0;
    end
    else
    begin
      // Returned qubits clear, a new MEASURE sets
      pending <= (pending & ~(i_meas_valid ? i_meas_qubits : '0))
               | ((i_dec.opcode == OP_MEASURE) ? i_issue_mask : '0);
      if (i_meas_valid)
      begin
        results <= (results & ~i_meas_qubits) | (i_meas_results & i_meas_qubits);
      end
      case (state)
        FMR_IDLE:
          if (fmr_new)
          begin
            if (!fmr_hit)
              state <= FMR_WAIT;
            else if (!i_grant)
              state <= FMR_WRITE;
          end
        FMR_WAIT:
          if (sel_covered)
            state <= FMR_WRITE;
        FMR_WRITE:
          if (i_grant)
            state <= FMR_IDLE;
        default:
          state <= FMR_IDLE;
      endcase
    end
  end

  // Captured destination and qubit
  always_ff @(posedge clk)
  begin
    if (fmr_new)
    begin
      rd_q    <= i_dec.rd;
      qubit_q <= i_dec.qubit;
    end
  end

  // Only one FMR in flight
  a_single_fmr: assert property (@(posedge clk) disable iff (i_reset)
    (i_dec.opcode == OP_FMR) |-> (state == FMR_IDLE))
    else $error("FMR issued while previous FMR still outstanding");

endmodule

//--- qpu_alu.sv
`timescale 1ns/1ps

module qpu_alu import qpu_pkg::*;
(
  input  qpu_dec_t    i_dec,
  output qpu_ridx_t   o_rs1_idx,
  output qpu_ridx_t   o_rs2_idx,
  input  qpu_word_t   i_rs1_data,
  input  qpu_word_t   i_rs2_data,
  output qpu_wb_req_t o_wb
);

  qpu_word_t op_b;

  // Register file reads straight from the decoded fields
  assign o_rs1_idx = i_dec.rs1;
  assign o_rs2_idx = i_dec.rs2;

  // Second operand
  assign op_b = (i_dec.opcode == OP_ADDI) ? i_dec.imm : i_rs2_data;

  always_comb
  begin
    o_wb     = '0;
    o_wb.idx = i_dec.rd;
    case (i_dec.opcode)
      OP_ADD, OP_ADDI:
      begin
        o_wb.valid = 1'b1;
        o_wb.data  = i_rs1_data + op_b;
      end
      OP_SUB:
      begin
        o_wb.valid = 1'b1;
        o_wb.data  = i_rs1_data - op_b;
      end
      // not an ALU op
      default:
        o_wb.valid = 1'b0;
    endcase
  end

endmodule

//--- qpu_decoder.sv
`timescale 1ns/1ps
`include "qpu_macros.svh"

module qpu_decoder import qpu_pkg::*;
(
  input  logic      i_instr_valid,
  input  qpu_word_t i_instr,
  output qpu_dec_t  o_dec
);

  logic [`QPU_OPC_MSB:`QPU_OPC_LSB] opc_raw;
  logic [`QPU_IMM_MSB:`QPU_IMM_LSB] imm_raw;

  assign opc_raw = i_instr[`QPU_OPC_MSB:`QPU_OPC_LSB];
  assign imm_raw = i_instr[`QPU_IMM_MSB:`QPU_IMM_LSB];

  always_comb
  begin
    o_dec          = '0;
    o_dec.valid    = i_instr_valid;
    // Register indices
    o_dec.rd       = i_instr[`QPU_RD_MSB:`QPU_RD_LSB];
    o_dec.rs1      = i_instr[`QPU_RS1_MSB:`QPU_RS1_LSB];
    o_dec.rs2      = i_instr[`QPU_RS2_MSB:`QPU_RS2_LSB];
    // ADDI immediate, sign extended to a full word
    o_dec.imm      = {{(`QPU_XLEN-`QPU_IMM_MSB-1){imm_raw[`QPU_IMM_MSB]}}, imm_raw};
    // Quantum fields
    o_dec.gate     = i_instr[`QPU_GATE_MSB:`QPU_GATE_LSB];
    o_dec.mask     = i_instr[`QPU_MASK_MSB:`QPU_MASK_LSB];
    o_dec.wait_amt = i_instr[`QPU_WAIT_MSB:`QPU_WAIT_LSB];
    o_dec.qubit    = i_instr[`QPU_QUBIT_MSB:`QPU_QUBIT_LSB];

    // Known opcodes pass, the rest become NOP
    case (qpu_opcode_e'(opc_raw))
      OP_SMIS, OP_QWAIT, OP_QOP, OP_MEASURE,
      OP_FMR, OP_ADDI, OP_ADD, OP_SUB:
        o_dec.opcode = qpu_opcode_e'(opc_raw);
      default:
        o_dec.opcode = OP_NOP;
    endcase

    // No strobe means nothing to execute
    if (!i_instr_valid)
    begin
      o_dec.opcode = OP_NOP;
    end
  end

endmodule

//--- qpu_pkg.sv
`include "qpu_macros.svh"

package qpu_pkg;

  // Plain vectors with a meaning
  typedef logic [`QPU_XLEN-1:0]         qpu_word_t;
  typedef logic [$clog2(`QPU_RF_NUM)-1:0] qpu_ridx_t;
  typedef logic [`QPU_QUBIT_NUM-1:0]    qpu_qmask_t;
  typedef logic [`QPU_TIME_WIDTH-1:0]   qpu_time_t;
  typedef logic [`QPU_GATE_WIDTH-1:0]   qpu_gate_t;

  // Opcode field encoding
  typedef enum logic [3:0] {
    OP_NOP     = 4'd0,
    OP_SMIS    = 4'd1,
    OP_QWAIT   = 4'd2,
    OP_QOP     = 4'd3,
    OP_MEASURE = 4'd4,
    OP_FMR     = 4'd5,
    OP_ADDI    = 4'd6,
    OP_ADD     = 4'd7,
    OP_SUB     = 4'd8
  } qpu_opcode_e;

  // FMR tracker states
  typedef enum logic [1:0] {
    FMR_IDLE  = 2'd0,
    FMR_WAIT  = 2'd1,
    FMR_WRITE = 2'd2
  } qpu_fmr_state_e;

  // Decoded instruction, fields split out
  typedef struct packed {
    logic                                valid;
    qpu_opcode_e                         opcode;
    qpu_ridx_t                           rd;
    qpu_ridx_t                           rs1;
    qpu_ridx_t                           rs2;
    qpu_word_t                           imm;
    qpu_gate_t                           gate;
    qpu_qmask_t                          mask;
    logic [`QPU_WAIT_MSB:`QPU_WAIT_LSB]   wait_amt;
    logic [`QPU_QUBIT_MSB:`QPU_QUBIT_LSB] qubit;
  } qpu_dec_t;

  // Timed event, 48 bits
  typedef struct packed {
    qpu_time_t  tp;
    qpu_gate_t  gate;
    qpu_qmask_t mask;
  } qpu_event_t;

  // Register file write request
  typedef struct packed {
    logic      valid;
    qpu_ridx_t idx;
    qpu_word_t data;
  } qpu_wb_req_t;

endpackage

//--- qpu_macros.svh
`ifndef QPU_MACROS_SVH
`define QPU_MACROS_SVH

////////////////////////////////////////////////////////////////////
// Datapath widths and array sizes

// Classical word and register file
`define QPU_XLEN        32
`define QPU_RF_NUM      16

// Qubit mask registers and qubit count
`define QPU_SR_NUM      16
`define QPU_QUBIT_NUM   8

// Timing and gate encoding
`define QPU_TIME_WIDTH  32
`define QPU_GATE_WIDTH  8

// Event FIFO entries
`define QPU_EVQ_DEPTH   8

////////////////////////////////////////////////////////////////////
// Instruction word fields

`define QPU_OPC_MSB     31
`define QPU_OPC_LSB     28
`define QPU_RD_MSB      27
`define QPU_RD_LSB      24
`define QPU_RS1_MSB     23
`define QPU_RS1_LSB     20
`define QPU_RS2_MSB     19
`define QPU_RS2_LSB     16
// Gate code overlaps rs1/rs2 on quantum ops
`define QPU_GATE_MSB    23
`define QPU_GATE_LSB    16
`define QPU_IMM_MSB     15
`define QPU_IMM_LSB     0
`define QPU_WAIT_MSB    19
`define QPU_WAIT_LSB    0
`define QPU_MASK_MSB    7
`define QPU_MASK_LSB    0
`define QPU_QUBIT_MSB   2
`define QPU_QUBIT_LSB   0

`endif
